//--- common/debounce_pkg.sv
// debounce package: channel count, filter counter width, sync depth, channel and event types

`default_nettype none

package debounce_pkg;

   // ############################
   // sizes
   // ############################

   localparam int NUM_CH      = 4;   // input pins
   localparam int CNT_W       = 4;   // filter counter, 2^CNT_W-1 cycles window
   localparam int SYNC_STAGES = 2;   // flops per synchronizer chain

   // ############################
   // types
   // ############################

   // one bit per pin
   typedef logic [NUM_CH-1:0] ch_vec_t;

   // rise and fall per channel
   // used for pulses, sticky flags, clear strobes and enable mask
   typedef struct packed {
      ch_vec_t rise;   // 0->1 on clean level
      ch_vec_t fall;   // 1->0 on clean level
   } edge_evt_t;

endpackage

`default_nettype wire

//--- hw/sync_stage.sv
// sync stage: pin vector synchronizer and filter reset synchronizer

`default_nettype none

module sync_stage (
   input  logic                 clk,
   input  logic                 nreset,      // async, active low
   input  debounce_pkg::ch_vec_t pins,       // raw switch pins
   output debounce_pkg::ch_vec_t pins_sync,  // pins in clk domain
   output logic                 filt_nreset  // reset for the filters, sync release
);

   // ############################
   // pin synchronizer
   // ############################

   // stage 0 samples the pins, last stage is the output
   logic [debounce_pkg::SYNC_STAGES-1:0][debounce_pkg::NUM_CH-1:0] pin_q;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         pin_q <= '0;
      end else begin
         pin_q <= {pin_q[debounce_pkg::SYNC_STAGES-2:0], pins}; // shift in
      end
   end

   assign pins_sync = pin_q[debounce_pkg::SYNC_STAGES-1];

   // ############################
   // reset synchronizer
   // ############################

   // asserts with nreset, releases after SYNC_STAGES edges
   logic [debounce_pkg::SYNC_STAGES-1:0] rst_q;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         rst_q <= '0;
      end else begin
         rst_q <= {rst_q[debounce_pkg::SYNC_STAGES-2:0], 1'b1}; // ones walk through
      end
   end

   assign filt_nreset = rst_q[debounce_pkg::SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- debounce/debounce_channel.sv
// debounce channel: change detector, saturating filter counter, clean output register

`default_nettype none

module debounce_channel (
   input  logic clk,
   input  logic nreset,       // async, active low
   input  logic filt_nreset,  // synchronized reset, reloads counter
   input  logic noisy,        // synced pin, still bouncing
   output logic clean         // debounced level
);

   // ############################
   // change detect
   // ############################

   logic                           prev;     // last synced sample
   logic                           change;   // input moved since last edge
   logic [debounce_pkg::CNT_W-1:0] cnt;      // cycles since last change
   logic                           carry;    // counter saturated, level stable

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         prev <= 1'b0;
      end else begin
         prev <= noisy;
      end
   end

   assign change = noisy ^ prev;

   // ############################
   // filter counter
   // ############################

   assign carry = &cnt;   // all ones

   // any change restarts the window
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         cnt <= '0;
      end else if (change || !filt_nreset) begin
         cnt <= '0;                    // reload
      end else if (!carry) begin
         cnt <= cnt + 1'b1;            // count up, hold at max
      end
   end

   // ############################
   // clean output
   // ############################

   // only sampled once the window has run out,
   // shorter bounces never reach here
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clean <= 1'b0;
      end else if (carry) begin
         clean <= prev;                // stable value
      end
   end

endmodule

`default_nettype wire

//--- hw/edge_events.sv
// edge events: edge detect on clean levels, sticky rise and fall flags, masked interrupt

`default_nettype none

module edge_events (
   input  logic                    clk,
   input  logic                    nreset,      // async, active low
   input  debounce_pkg::ch_vec_t   clean,       // debounced levels
   input  debounce_pkg::edge_evt_t evt_clear,   // one-cycle clear strobe
   input  debounce_pkg::edge_evt_t evt_enable,  // irq mask
   output debounce_pkg::edge_evt_t evt_flags,   // sticky flags
   output logic                    irq          // any enabled flag
);

   // ############################
   // edge detect
   // ############################

   debounce_pkg::ch_vec_t   clean_q;     // clean one edge ago
   debounce_pkg::edge_evt_t evt_pulse;   // single-cycle edge pulses

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         clean_q <= '0;
      end else begin
         clean_q <= clean;
      end
   end

   always_comb begin
      evt_pulse.rise = clean & ~clean_q;   // was 0, now 1
      evt_pulse.fall = ~clean & clean_q;   // was 1, now 0
   end

   // ############################
   // sticky flags
   // ############################

   // clear first, then set on top
   // so a new edge wins over a same-cycle clear
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         evt_flags <= '0;
      end else begin
         evt_flags.rise <= (evt_flags.rise & ~evt_clear.rise) | evt_pulse.rise;
         evt_flags.fall <= (evt_flags.fall & ~evt_clear.fall) | evt_pulse.fall;
      end
   end

   // ############################
   // interrupt
   // ############################

   debounce_pkg::edge_evt_t evt_masked;   // flags that may raise irq

   always_comb begin
      evt_masked.rise = evt_flags.rise & evt_enable.rise;
      evt_masked.fall = evt_flags.fall & evt_enable.fall;
   end

   // plain level, stays up until software clears
   assign irq = |evt_masked;

endmodule

`default_nettype wire

//--- hw/button_input_top.sv
// button input top: sync stage, per-pin debounce channels and edge event unit

`default_nettype none

module button_input_top (
   input  logic                    clk,
   input  logic                    nreset,      // async, active low
   input  debounce_pkg::ch_vec_t   pins,        // raw pins, async
   input  debounce_pkg::edge_evt_t evt_clear,   // flag clear strobe
   input  debounce_pkg::edge_evt_t evt_enable,  // irq mask
   output debounce_pkg::ch_vec_t   clean,       // debounced levels
   output debounce_pkg::edge_evt_t evt_flags,   // sticky edge flags
   output logic                    irq
);

   debounce_pkg::ch_vec_t pins_sync;    // pins in clk domain
   logic                  filt_nreset;  // reset for the filter counters

   // ############################
   // synchronizers
   // ############################

   sync_stage u_sync (
      .clk         (clk),
      .nreset      (nreset),
      .pins        (pins),
      .pins_sync   (pins_sync),
      .filt_nreset (filt_nreset)
   );

   // ############################
   // filters, one per pin
   // ############################

   for (genvar i = 0; i < debounce_pkg::NUM_CH; i++) begin : g_ch
      debounce_channel u_deb (
         .clk         (clk),
         .nreset      (nreset),
         .filt_nreset (filt_nreset),
         .noisy       (pins_sync[i]),
         .clean       (clean[i])
      );
   end

   // ############################
   // edge flags and irq
   // ############################

   edge_events u_evt (
      .clk        (clk),
      .nreset     (nreset),
      .clean      (clean),
      .evt_clear  (evt_clear),
      .evt_enable (evt_enable),
      .evt_flags  (evt_flags),
      .irq        (irq)
   );

endmodule

`default_nettype wire

//--- tb/button_input_asserts.sv
// bound checker: concurrent assertions on filter stability, irq masking and reset values

`default_nettype none

module button_input_asserts (
   input logic                    clk,
   input logic                    nreset,
   input debounce_pkg::ch_vec_t   pins,
   input debounce_pkg::edge_evt_t evt_enable,
   input debounce_pkg::ch_vec_t   clean,
   input debounce_pkg::edge_evt_t evt_flags,
   input logic                    irq
);

   int assert_errors = 0;   // failed assertions, summed by the bench

   debounce_pkg::ch_vec_t                pins_q;   // pins one edge ago
   logic [debounce_pkg::NUM_CH-1:0][4:0] run;      // edges each pin held still, saturates

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         pins_q <= '0;
         run    <= '0;
      end else begin
         pins_q <= pins;
         for (int i = 0; i < debounce_pkg::NUM_CH; i++) begin
            if (pins[i] != pins_q[i]) begin
               run[i] <= '0;              // pin moved
            end else if (run[i] != 5'd31) begin
               run[i] <= run[i] + 5'd1;
            end
         end
      end
   end

   // ############################
   // filter
   // ############################

   // clean only moves to a level the pin has held for a full window
   for (genvar i = 0; i < debounce_pkg::NUM_CH; i++) begin : g_ch
      a_clean_stable: assert property (@(posedge clk) disable iff (!nreset)
         $changed(clean[i]) |-> (pins[i] == clean[i]) && (run[i] >= 5'd15))
      else begin
         assert_errors++;
         $error("clean[%0d] changed without the pin steady at that level", i);
      end
   end

   // ############################
   // irq and reset
   // ############################

   a_irq_mask: assert property (@(posedge clk)
      irq == |{evt_flags.rise & evt_enable.rise, evt_flags.fall & evt_enable.fall})
   else begin
      assert_errors++;
      $error("irq does not match the enabled flags");
   end

   a_reset_zero: assert property (@(posedge clk)
      !nreset |-> (clean == '0) && (evt_flags == '0) && !irq)
   else begin
      assert_errors++;
      $error("an output is not zero during reset");
   end

endmodule

bind button_input_top button_input_asserts u_asserts (
   .clk        (clk),
   .nreset     (nreset),
   .pins       (pins),
   .evt_enable (evt_enable),
   .clean      (clean),
   .evt_flags  (evt_flags),
   .irq        (irq)
);

`default_nettype wire

//--- tb/tb_button_input.sv
// testbench for button_input_top: clock, reset, xorshift bounce stimulus, level and flag model

`default_nettype none

module tb_button_input;

   // ############################
   // constants
   // ############################

   localparam int          CLK_PERIOD  = 4;
   localparam logic [31:0] SEED        = 32'd25366;
   localparam int          NUM_CH      = debounce_pkg::NUM_CH;
   localparam int          SEG_MAX     = 10;   // longest bounce segment
   localparam int          GLITCH_MAX  = 14;   // longest glitch, inside the filter window
   localparam int          FILTER_CYC  = 15;   // below this clean must not move
   localparam int          CLEAN_DELAY = 19;   // pin change to clean change
   localparam int          SETTLE_MAX  = 21;   // clean has followed by now
   localparam int          ACCEPT_CYC  = 24;   // model takes the level here
   localparam int          HOLD_CYC    = 30;   // steady hold after a bounce
   localparam int          STEADY_CAP  = 1000;
   localparam int          RUN_MAX     = 6 * SEG_MAX + HOLD_CYC;   // one bounce round
   localparam int          TEST_CYC    = 6 + 40 + NUM_CH * RUN_MAX        // reset, idle, settle
                                         + 16 * 2 * GLITCH_MAX + HOLD_CYC  // glitches
                                         + 8 + HOLD_CYC + RUN_MAX          // flag clears
                                         + 16 * 3 + 4 * (RUN_MAX + 1);     // masks, random

   // ############################
   // signals and model
   // ############################

   logic                    clk = 1'b0;
   logic                    nreset;
   debounce_pkg::ch_vec_t   pins;
   debounce_pkg::edge_evt_t evt_clear;
   debounce_pkg::edge_evt_t evt_enable;
   debounce_pkg::ch_vec_t   clean;
   debounce_pkg::edge_evt_t evt_flags;
   logic                    irq;

   debounce_pkg::ch_vec_t   model_level;       // level accepted by the model
   debounce_pkg::edge_evt_t model_flags;       // expected sticky flags
   int                      steady [NUM_CH];   // cycles since the pin last moved
   int                      errors = 0;
   logic [31:0]             rng = SEED;

   button_input_top UUT (
      .clk        (clk),
      .nreset     (nreset),
      .pins       (pins),
      .evt_clear  (evt_clear),
      .evt_enable (evt_enable),
      .clean      (clean),
      .evt_flags  (evt_flags),
      .irq        (irq)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int next_rand(input int lo, input int hi);
      rng = xorshift(rng);
      return lo + int'(rng % (hi - lo + 1));
   endfunction

   task automatic report_fail(input string msg);
      errors++;
      $display("[FAIL] t=%0t %s", $time, msg);
   endtask

   // flags and irq are only compared outside a channel's acceptance window
   task automatic check_outputs();
      logic window;
      window = 1'b0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         if (steady[ch] >= SETTLE_MAX) begin
            assert (clean[ch] == pins[ch])
               else report_fail($sformatf("ch%0d clean %b after %0d steady cycles at %b",
                                          ch, clean[ch], steady[ch], pins[ch]));
         end else if (steady[ch] < FILTER_CYC) begin
            assert (clean[ch] == model_level[ch])
               else report_fail($sformatf("ch%0d clean %b left level %b during bounce",
                                          ch, clean[ch], model_level[ch]));
         end
         if (steady[ch] >= FILTER_CYC && steady[ch] < ACCEPT_CYC) begin
            window = 1'b1;
         end else begin
            assert (evt_flags.rise[ch] == model_flags.rise[ch]
                    && evt_flags.fall[ch] == model_flags.fall[ch])
               else report_fail($sformatf("ch%0d flags rise %b fall %b, expected %b %b", ch,
                                          evt_flags.rise[ch], evt_flags.fall[ch],
                                          model_flags.rise[ch], model_flags.fall[ch]));
         end
      end
      if (!window) begin
         assert (irq == |{model_flags.rise & evt_enable.rise, model_flags.fall & evt_enable.fall})
            else report_fail($sformatf("irq %b with flags %h enable %h",
                                       irq, model_flags, evt_enable));
      end
   endtask

   // one clock, then model update and checks, drive window open on return
   task automatic step();
      @(posedge clk);
      #1;
      evt_clear = '0;   // strobe lasts one cycle
      for (int ch = 0; ch < NUM_CH; ch++) begin
         if (steady[ch] < STEADY_CAP) begin
            steady[ch]++;
         end
         if (steady[ch] == ACCEPT_CYC && pins[ch] != model_level[ch]) begin
            model_level[ch] = pins[ch];
            if (pins[ch]) begin
               model_flags.rise[ch] = 1'b1;
            end else begin
               model_flags.fall[ch] = 1'b1;
            end
         end
      end
      check_outputs();
   endtask

   task automatic drive_pin(input int ch, input logic level);
      if (pins[ch] != level) begin
         steady[ch] = 0;
      end
      pins[ch] = level;
   endtask

   task automatic clear_flags(input debounce_pkg::edge_evt_t mask);
      evt_clear        = mask;
      model_flags.rise = model_flags.rise & ~mask.rise;
      model_flags.fall = model_flags.fall & ~mask.fall;
   endtask

   // selected pins bounce 2..6 segments, then hold their target
   task automatic bounce_group(input debounce_pkg::ch_vec_t sel,
                               input debounce_pkg::ch_vec_t level,
                               input logic pick_level);
      int   segs [NUM_CH];
      int   seg_left [NUM_CH];
      logic target [NUM_CH];
      logic busy;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         segs[ch]     = sel[ch] ? next_rand(2, 6) : 0;
         seg_left[ch] = 0;
         target[ch]   = pick_level ? (next_rand(0, 1) == 1) : level[ch];
      end
      busy = 1'b1;
      while (busy) begin
         busy = 1'b0;
         for (int ch = 0; ch < NUM_CH; ch++) begin
            if (seg_left[ch] == 0 && segs[ch] > 0) begin
               segs[ch]--;
               drive_pin(ch, (segs[ch] == 0) ? target[ch] : ~pins[ch]);
               seg_left[ch] = (segs[ch] == 0) ? HOLD_CYC : next_rand(1, SEG_MAX);
            end
            if (seg_left[ch] > 0) begin
               busy = 1'b1;
            end
         end
         if (busy) begin
            step();
            for (int ch = 0; ch < NUM_CH; ch++) begin
               if (seg_left[ch] > 0) begin
                  seg_left[ch]--;
               end
            end
         end
      end
   endtask

   task automatic glitch_burst(input int reps);
      debounce_pkg::ch_vec_t base;
      debounce_pkg::ch_vec_t mask;
      int                    r;
      base = pins;
      for (int k = 0; k < reps; k++) begin
         r    = next_rand(1, (1 << NUM_CH) - 1);
         mask = r[NUM_CH-1:0];
         for (int ch = 0; ch < NUM_CH; ch++) begin
            drive_pin(ch, base[ch] ^ mask[ch]);
         end
         repeat (next_rand(1, GLITCH_MAX)) step();
         for (int ch = 0; ch < NUM_CH; ch++) begin
            drive_pin(ch, base[ch]);
         end
         repeat (next_rand(1, GLITCH_MAX)) step();
      end
      repeat (HOLD_CYC) step();
   endtask

   // clear lands on the edge where the flag sets
   task automatic settle_with_clear(input int ch, input logic level);
      debounce_pkg::edge_evt_t mask;
      mask = '0;
      if (level) begin
         mask.rise[ch] = 1'b1;
      end else begin
         mask.fall[ch] = 1'b1;
      end
      drive_pin(ch, level);
      repeat (CLEAN_DELAY) step();   // clean just moved, pulse is up
      clear_flags(mask);
      repeat (HOLD_CYC - CLEAN_DELAY) step();
   endtask

   // zero, all, single bits, then random masks
   task automatic mask_sweep();
      logic [2*NUM_CH-1:0] bits;
      int                  r;
      for (int k = 0; k < 16; k++) begin
         bits = '0;
         if (k == 1) begin
            bits = '1;
         end else if (k >= 2 && k < 2 + 2 * NUM_CH) begin
            bits[k-2] = 1'b1;
         end else if (k > 1) begin
            r    = next_rand(0, (1 << (2 * NUM_CH)) - 1);
            bits = r[2*NUM_CH-1:0];
         end
         evt_enable = bits;
         repeat (3) step();
      end
   endtask

   // ############################
   // test sequence
   // ############################

   initial begin
      debounce_pkg::ch_vec_t   sel;
      debounce_pkg::edge_evt_t mask;
      pins        = '0;
      evt_clear   = '0;
      evt_enable  = '0;
      nreset      = 1'b1;
      model_level = '0;
      model_flags = '0;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         steady[ch] = STEADY_CAP;
      end
      #1;
      nreset = 1'b0;                  // async assert before the first edge
      repeat (5) @(posedge clk);
      #1;
      nreset = 1'b1;

      repeat (40) step();             // idle, everything stays low

      evt_enable = '1;
      for (int ch = 0; ch < NUM_CH; ch++) begin
         sel     = '0;
         sel[ch] = 1'b1;
         bounce_group(sel, '1, 1'b0);   // each pin up on its own
      end

      glitch_burst(16);               // clean stays high throughout

      mask      = '0;
      mask.rise = 4'b0101;
      clear_flags(mask);              // rise 0 and 2 only
      repeat (4) step();
      settle_with_clear(1, 1'b0);     // fall[1] survives its clear
      mask         = '0;
      mask.fall[1] = 1'b1;
      clear_flags(mask);
      repeat (4) step();
      bounce_group(4'b1000, 4'b0000, 1'b0);

      mask_sweep();

      evt_enable = '1;
      repeat (4) begin
         bounce_group('1, '0, 1'b1);  // all pins, random targets
         clear_flags('1);
         step();
      end

      $display("closing: %0d bench errors, %0d assertion errors",
               errors, UUT.u_asserts.assert_errors);
      if (errors == 0 && UUT.u_asserts.assert_errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // watchdog, half again the summed phase lengths
   initial begin
      #(TEST_CYC * CLK_PERIOD * 3 / 2);
      $display("watchdog: the test phases did not finish in time, run stopped");
      $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
common/debounce_pkg.sv
hw/sync_stage.sv
debounce/debounce_channel.sv
hw/edge_events.sv
hw/button_input_top.sv
tb/button_input_asserts.sv
tb/tb_button_input.sv
